/* verilog/cu_bus_pkg.sv */
/*
 * memory bus definitions for the compute unit shell
 * command, response and read data lines tagged with the issuing cu id
 */

package cu_bus_pkg;

	// compute unit id carried in every command tag
	typedef logic [7:0] cu_id_t;

	// traffic owned by the vertex job client
	localparam cu_id_t VERTEX_CONTROL_ID = 8'h01;

	localparam int ADDR_BITS = 64;
	localparam int DATA_BITS = 512;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [7:0]           tag_t;
	typedef logic [7:0]           size_t;
	typedef logic [7:0]           resp_code_t;

	typedef struct packed {
		cu_id_t cu_id;
		tag_t   tag;
	} cmd_tag_t;

	typedef struct packed {
		logic     valid;
		addr_t    address;
		size_t    size;
		cmd_tag_t cmd;
	} read_command_t;

	typedef struct packed {
		logic       valid;
		cmd_tag_t   cmd;
		resp_code_t response;
	} read_response_t;

	// one full cache line of read data
	typedef struct packed {
		logic                 valid;
		cmd_tag_t             cmd;
		logic [DATA_BITS-1:0] data;
	} read_data_t;

endpackage

/* verilog/cu_job_pkg.sv */
/*
 * job level definitions for the compute unit shell
 * work descriptor, configuration words and the completion return value
 */

package cu_job_pkg;

	localparam int VERTEX_BITS = 32;
	localparam int EDGE_BITS   = 32;
	localparam int CONFIG_BITS = 64;

	typedef logic [VERTEX_BITS-1:0] vertex_count_t;
	typedef logic [EDGE_BITS-1:0]   edge_count_t;
	typedef logic [CONFIG_BITS-1:0] config_word_t;

	// work element descriptor
	typedef struct packed {
		logic          valid;
		vertex_count_t num_vertices;
		edge_count_t   num_edges;
	} wed_t;

	typedef struct packed {
		config_word_t var1;
		config_word_t var2;
	} cu_configure_t;

	// var1 holds the vertex total, var2 the edge total
	typedef struct packed {
		vertex_count_t var1;
		edge_count_t   var2;
	} cu_return_t;

endpackage

/* verilog/cu_config_latch.sv */
/*
 * job context latch
 * registers the enable level, the work descriptor and the configuration,
 * and raises the unit enable once the unit is configured
 */

`timescale 1ns/10ps

module cu_config_latch (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled_in,
	input  cu_job_pkg::wed_t          wed_request_in,
	input  cu_job_pkg::cu_configure_t cu_configure,
	output logic                      enabled,
	output logic                      unit_enable,
	output cu_job_pkg::wed_t          wed_latched,
	output cu_job_pkg::config_word_t  cu_status
);

	import cu_job_pkg::*;

	config_word_t config_latched;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled        <= 1'b0;
			unit_enable    <= 1'b0;
			wed_latched    <= '0;
			config_latched <= '0;
			cu_status      <= '0;
		end else begin
			enabled     <= enabled_in;
			unit_enable <= (|config_latched) && wed_latched.valid;
			if (enabled) begin
				wed_latched <= wed_request_in;
				cu_status   <= config_latched;
				// zero words are idle bus cycles, keep the last configuration
				if (|cu_configure.var1)
					config_latched <= cu_configure.var1;
			end
		end
	end

	// the unit only starts on a descriptor that was valid the cycle before
	a_enable_needs_wed: assert property (@(posedge clock) disable iff (!rstn)
		$rose(unit_enable) |-> $past(wed_latched.valid));

endmodule

/* verilog/cu_response_router.sv */
/*
 * read response and read data router
 * latches each stream and steers items to the vertex job client or the
 * graph algorithm client by the cu id of the command tag
 */

`timescale 1ns/10ps

module cu_response_router (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  cu_bus_pkg::read_response_t read_response_in,
	input  cu_bus_pkg::read_data_t     read_data_in,
	output cu_bus_pkg::read_response_t vertex_response,
	output cu_bus_pkg::read_response_t graph_response,
	output cu_bus_pkg::read_data_t     vertex_data,
	output cu_bus_pkg::read_data_t     graph_data
);

	import cu_bus_pkg::*;

	read_response_t response_latched;
	read_data_t     data_latched;

//////////////////////////////////////////////////////////////////////
// stage one latches the inputs
//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_latched <= '0;
			data_latched     <= '0;
		end else if (enabled) begin
			response_latched <= read_response_in;
			data_latched     <= read_data_in;
		end
	end

//////////////////////////////////////////////////////////////////////
// stage two steers by cu id
//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_response <= '0;
			graph_response  <= '0;
		end else begin
			vertex_response <= '0;
			graph_response  <= '0;
			if (enabled && response_latched.valid) begin
				if (response_latched.cmd.cu_id == VERTEX_CONTROL_ID)
					vertex_response <= response_latched;
				else
					graph_response <= response_latched;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_data <= '0;
			graph_data  <= '0;
		end else begin
			vertex_data <= '0;
			graph_data  <= '0;
			if (enabled && data_latched.valid) begin
				if (data_latched.cmd.cu_id == VERTEX_CONTROL_ID)
					vertex_data <= data_latched;
				else
					graph_data <= data_latched;
			end
		end
	end

	// a client port never sees another client's item in the same cycle
	a_ports_exclusive: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_response.valid && graph_response.valid) &&
		!(vertex_data.valid && graph_data.valid));

endmodule

/* verilog/cu_read_arbiter.sv */
/*
 * read command arbiter
 * round robin merge of the vertex job and graph algorithm read commands
 * toward memory, with a registered command output
 */

`timescale 1ns/10ps

module cu_read_arbiter (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      unit_enable,
	input  cu_bus_pkg::read_command_t vertex_command,
	input  cu_bus_pkg::read_command_t graph_command,
	output logic                      vertex_grant,
	output logic                      graph_grant,
	output cu_bus_pkg::read_command_t read_command_out
);

	import cu_bus_pkg::*;

	// client that wins a tie next
	typedef enum logic {
		PRIO_VERTEX,
		PRIO_GRAPH
	} prio_t;

	prio_t         prio;
	read_command_t next_command;

	// grant in the same cycle as the request
	assign vertex_grant = unit_enable && vertex_command.valid &&
		(!graph_command.valid || prio == PRIO_VERTEX);
	assign graph_grant  = unit_enable && graph_command.valid &&
		(!vertex_command.valid || prio == PRIO_GRAPH);

	always_comb begin
		next_command = '0;
		if (vertex_grant)
			next_command = vertex_command;
		else if (graph_grant)
			next_command = graph_command;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prio             <= PRIO_VERTEX;
			read_command_out <= '0;
		end else begin
			read_command_out <= next_command;
			// the loser of this round wins the next tie
			if (vertex_grant)
				prio <= PRIO_GRAPH;
			else if (graph_grant)
				prio <= PRIO_VERTEX;
		end
	end

	a_one_grant: assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_grant && graph_grant) &&
		(!vertex_grant || vertex_command.valid) &&
		(!graph_grant || graph_command.valid));

endmodule

/* verilog/cu_done_tracker.sv */
/*
 * completion tracker
 * totals the processed and filtered vertex counts, compares vertex and
 * edge totals with the descriptor and raises cu_done with the return value
 */

`timescale 1ns/10ps

module cu_done_tracker (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic                      unit_enable,
	input  cu_job_pkg::wed_t          wed_latched,
	input  cu_job_pkg::vertex_count_t vertex_done_count,
	input  cu_job_pkg::vertex_count_t vertex_filtered_count,
	input  cu_job_pkg::edge_count_t   edge_done_count,
	output logic                      cu_done,
	output cu_job_pkg::cu_return_t    cu_return
);

	import cu_job_pkg::*;

	vertex_count_t vertex_done_latched;
	vertex_count_t vertex_total;
	edge_count_t   edge_done_latched;
	edge_count_t   edge_total;
	cu_return_t    return_stage;
	logic          counts_match;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_latched <= '0;
			vertex_total        <= '0;
			edge_done_latched   <= '0;
			edge_total          <= '0;
			cu_return           <= '0;
		end else if (enabled) begin
			vertex_done_latched <= vertex_done_count;
			edge_done_latched   <= edge_done_count;
			// edges take an extra stage to line up with the vertex sum
			vertex_total        <= vertex_done_latched + vertex_filtered_count;
			edge_total          <= edge_done_latched;
			cu_return           <= return_stage;
		end
	end

	// compare stage, then the done flag
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			return_stage <= '0;
			counts_match <= 1'b0;
			cu_done      <= 1'b0;
		end else begin
			if (unit_enable) begin
				return_stage.var1 <= vertex_total;
				return_stage.var2 <= edge_total;
			end
			counts_match <= unit_enable &&
				(wed_latched.num_vertices == vertex_total) &&
				(wed_latched.num_edges == edge_total);
			cu_done      <= counts_match && unit_enable;
		end
	end

	a_done_needs_unit: assert property (@(posedge clock) disable iff (!rstn)
		!unit_enable |=> !cu_done);

endmodule

/* verilog/cu_control.sv */
/*
 * graph compute unit control shell
 * job context latch, response routing to the two clients, read command
 * arbitration and completion reporting
 */

`timescale 1ns/10ps

module cu_control (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled_in,
	input  cu_job_pkg::wed_t          wed_request_in,
	input  cu_job_pkg::cu_configure_t cu_configure,
	input  cu_bus_pkg::read_response_t read_response_in,
	input  cu_bus_pkg::read_data_t    read_data_in,
	input  cu_bus_pkg::read_command_t vertex_command,
	input  cu_bus_pkg::read_command_t graph_command,
	input  cu_job_pkg::vertex_count_t vertex_done_count,
	input  cu_job_pkg::vertex_count_t vertex_filtered_count,
	input  cu_job_pkg::edge_count_t   edge_done_count,
	output cu_bus_pkg::read_response_t vertex_response,
	output cu_bus_pkg::read_response_t graph_response,
	output cu_bus_pkg::read_data_t    vertex_data,
	output cu_bus_pkg::read_data_t    graph_data,
	output logic                      vertex_grant,
	output logic                      graph_grant,
	output cu_bus_pkg::read_command_t read_command_out,
	output logic                      cu_done,
	output cu_job_pkg::cu_return_t    cu_return,
	output cu_job_pkg::config_word_t  cu_status
);

	import cu_job_pkg::*;

	logic enabled;
	logic unit_enable;
	wed_t wed_latched;

	cu_config_latch config_latch (
		.clock         (clock),
		.rstn          (rstn),
		.enabled_in    (enabled_in),
		.wed_request_in(wed_request_in),
		.cu_configure  (cu_configure),
		.enabled       (enabled),
		.unit_enable   (unit_enable),
		.wed_latched   (wed_latched),
		.cu_status     (cu_status)
	);

	// responses and data back to the clients
	cu_response_router response_router (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.read_response_in(read_response_in),
		.read_data_in    (read_data_in),
		.vertex_response (vertex_response),
		.graph_response  (graph_response),
		.vertex_data     (vertex_data),
		.graph_data      (graph_data)
	);

	// client read commands toward memory
	cu_read_arbiter read_arbiter (
		.clock           (clock),
		.rstn            (rstn),
		.unit_enable     (unit_enable),
		.vertex_command  (vertex_command),
		.graph_command   (graph_command),
		.vertex_grant    (vertex_grant),
		.graph_grant     (graph_grant),
		.read_command_out(read_command_out)
	);

	cu_done_tracker done_tracker (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled              (enabled),
		.unit_enable          (unit_enable),
		.wed_latched          (wed_latched),
		.vertex_done_count    (vertex_done_count),
		.vertex_filtered_count(vertex_filtered_count),
		.edge_done_count      (edge_done_count),
		.cu_done              (cu_done),
		.cu_return            (cu_return)
	);

endmodule

/* bench/cu_clock_gen.sv */
/*
 * testbench clock and reset
 * 4 ns clock, active low reset held for the first 16 cycles
 */

`timescale 1ns/10ps

module cu_clock_gen (
	output logic clock,
	output logic rstn
);

	localparam int RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// release just after an edge, in step with the other inputs
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 rstn = 1'b1;
	end

endmodule

/* bench/cu_control_tb.sv */
/*
 * testbench for the compute unit control shell
 * checks reset, configuration, response routing, read arbitration and
 * completion against a reference model of the timing rules
 */

`timescale 1ns/10ps

module cu_control_tb;

	import cu_bus_pkg::*;
	import cu_job_pkg::*;

	typedef logic [639:0] wide_t;

	// router outputs expected in one cycle
	typedef struct packed {
		int             due;
		read_response_t vertex_response;
		read_response_t graph_response;
		read_data_t     vertex_data;
		read_data_t     graph_data;
	} route_expect_t;

	localparam int RESET_CYCLES  = 16;
	localparam int ROUTE_ITEMS   = 8;
	localparam int ARB_ROUNDS    = 8;
	localparam int SINGLE_ROUNDS = 4;
	// reset check, configure, two routing passes, arbitration, completion, mismatch
	localparam int TEST_CYCLES = 1 + 9 + 2 * (ROUTE_ITEMS + 4) +
		(ARB_ROUNDS + SINGLE_ROUNDS + 2) + 4 + 16;
	localparam int CYCLE_LIMIT = RESET_CYCLES + TEST_CYCLES + 100;

	logic           clock;
	logic           rstn;
	logic           enabled_in;
	wed_t           wed_request_in;
	cu_configure_t  cu_configure;
	read_response_t read_response_in;
	read_data_t     read_data_in;
	read_command_t  vertex_command;
	read_command_t  graph_command;
	vertex_count_t  vertex_done_count;
	vertex_count_t  vertex_filtered_count;
	edge_count_t    edge_done_count;
	read_response_t vertex_response;
	read_response_t graph_response;
	read_data_t     vertex_data;
	read_data_t     graph_data;
	logic           vertex_grant;
	logic           graph_grant;
	read_command_t  read_command_out;
	logic           cu_done;
	cu_return_t     cu_return;
	config_word_t   cu_status;

	int            cycle = 0;
	int            checks = 0;
	int            errors = 0;
	int            test_errors = 0;
	int            tests_run = 0;
	int            tests_failed = 0;
	string         test_name;
	route_expect_t route_queue[$];

	cu_clock_gen clock_gen (.clock(clock), .rstn(rstn));

	cu_control UUT (.*);

//////////////////////////////////////////////////////////////////////
// cycle count and run limit
//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, the tests did not finish", cycle);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

	// each valid item leaves on the port chosen by its cu id
	function automatic route_expect_t route_reference(input read_response_t rsp,
			input read_data_t dat, input int due);
		route_expect_t e;
		e = '0;
		e.due = due;
		if (rsp.valid && rsp.cmd.cu_id == VERTEX_CONTROL_ID)
			e.vertex_response = rsp;
		else if (rsp.valid)
			e.graph_response = rsp;
		if (dat.valid && dat.cmd.cu_id == VERTEX_CONTROL_ID)
			e.vertex_data = dat;
		else if (dat.valid)
			e.graph_data = dat;
		return e;
	endfunction

	// returns {vertex grant, graph grant}, a tie goes to the client not granted last
	function automatic logic [1:0] grant_reference(input logic graph_first,
			input logic vertex_valid, input logic graph_valid);
		if (vertex_valid && (!graph_valid || !graph_first))
			return 2'b10;
		if (graph_valid)
			return 2'b01;
		return 2'b00;
	endfunction

	function automatic logic done_reference(input wed_t wed, input vertex_count_t done_count,
			input vertex_count_t filtered_count, input edge_count_t edge_count);
		vertex_count_t total;
		total = done_count + filtered_count;
		return wed.valid && total == wed.num_vertices && edge_count == wed.num_edges;
	endfunction

//////////////////////////////////////////////////////////////////////
// stimulus helpers
//////////////////////////////////////////////////////////////////////

	function automatic cu_id_t random_id(input logic to_vertex);
		cu_id_t id;
		id = cu_id_t'($urandom());
		if (to_vertex)
			id = VERTEX_CONTROL_ID;
		else if (id == VERTEX_CONTROL_ID)
			id = id + 8'd1;
		return id;
	endfunction

	function automatic read_response_t random_response(input logic to_vertex);
		read_response_t rsp;
		rsp.valid     = 1'b1;
		rsp.cmd.cu_id = random_id(to_vertex);
		rsp.cmd.tag   = tag_t'($urandom());
		rsp.response  = resp_code_t'($urandom());
		return rsp;
	endfunction

	function automatic read_data_t random_data(input logic to_vertex);
		read_data_t dat;
		dat.valid     = 1'b1;
		dat.cmd.cu_id = random_id(to_vertex);
		dat.cmd.tag   = tag_t'($urandom());
		for (int i = 0; i < DATA_BITS / 32; i++)
			dat.data[i*32 +: 32] = $urandom();
		return dat;
	endfunction

	function automatic read_command_t random_command();
		read_command_t cmd;
		cmd.valid     = 1'b1;
		cmd.address   = {$urandom(), $urandom()};
		cmd.size      = size_t'($urandom());
		cmd.cmd.cu_id = cu_id_t'($urandom());
		cmd.cmd.tag   = tag_t'($urandom());
		return cmd;
	endfunction

	task automatic check_value(input string what, input wide_t expected, input wide_t actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			test_errors++;
			$display("** Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %-13s ok", test_name);
		end else begin
			tests_failed++;
			$display("test %-13s %0d errors", test_name, test_errors);
		end
	endtask

//////////////////////////////////////////////////////////////////////
// tests
//////////////////////////////////////////////////////////////////////

	initial begin
		route_expect_t e;
		read_response_t rsp;
		read_data_t     dat;
		read_command_t  granted;
		cu_return_t     expected_return;
		config_word_t   first_var1;
		config_word_t   second_var1;
		vertex_count_t  done_part;
		logic [1:0]     grants;
		logic           graph_first;
		logic           to_vertex;
		logic           expected_done;

		void'($urandom(39));
		enabled_in            = 1'b0;
		wed_request_in        = '0;
		cu_configure          = '0;
		read_response_in      = '0;
		read_data_in          = '0;
		vertex_command        = '0;
		graph_command         = '0;
		vertex_done_count     = '0;
		vertex_filtered_count = '0;
		edge_done_count       = '0;
		@(posedge rstn);

		begin_test("reset");
		step();
		check_value("cu_done", wide_t'(1'b0), wide_t'(cu_done));
		check_value("vertex_grant", wide_t'(1'b0), wide_t'(vertex_grant));
		check_value("graph_grant", wide_t'(1'b0), wide_t'(graph_grant));
		check_value("vertex_response.valid", wide_t'(1'b0), wide_t'(vertex_response.valid));
		check_value("graph_response.valid", wide_t'(1'b0), wide_t'(graph_response.valid));
		check_value("vertex_data.valid", wide_t'(1'b0), wide_t'(vertex_data.valid));
		check_value("graph_data.valid", wide_t'(1'b0), wide_t'(graph_data.valid));
		check_value("cu_status", wide_t'(0), wide_t'(cu_status));
		check_value("cu_return", wide_t'(0), wide_t'(cu_return));
		end_test();

		begin_test("configure");
		first_var1  = {$urandom(), $urandom()} | 64'h1;
		second_var1 = first_var1 ^ ({$urandom(), $urandom()} | 64'h2);
		wed_request_in.valid        = 1'b1;
		wed_request_in.num_vertices = $urandom_range(1000, 1);
		wed_request_in.num_edges    = $urandom_range(4000, 1);
		cu_configure.var1           = first_var1;
		cu_configure.var2           = {$urandom(), $urandom()};
		enabled_in                  = 1'b1;
		repeat (3) step();
		check_value("cu_status after enable", wide_t'(first_var1), wide_t'(cu_status));
		cu_configure.var1 = '0;
		repeat (3) step();
		check_value("cu_status after zero var1", wide_t'(first_var1), wide_t'(cu_status));
		cu_configure.var1 = second_var1;
		repeat (3) step();
		check_value("cu_status after new var1", wide_t'(second_var1), wide_t'(cu_status));
		end_test();

		for (int pass = 0; pass < 2; pass++) begin
			to_vertex = (pass == 0);
			begin_test(to_vertex ? "route_vertex" : "route_graph");
			fork
				begin
					for (int i = 0; i < ROUTE_ITEMS; i++) begin
						rsp = random_response(to_vertex);
						dat = random_data(to_vertex);
						read_response_in = rsp;
						read_data_in     = dat;
						// one cycle to latch, one to route
						route_queue.push_back(route_reference(rsp, dat, cycle + 2));
						step();
					end
					read_response_in = '0;
					read_data_in     = '0;
				end
				begin
					repeat (ROUTE_ITEMS + 3) begin
						@(negedge clock);
						e = '0;
						if (route_queue.size() > 0 && route_queue[0].due == cycle)
							e = route_queue.pop_front();
						check_value("vertex_response", wide_t'(e.vertex_response),
							wide_t'(vertex_response));
						check_value("graph_response", wide_t'(e.graph_response),
							wide_t'(graph_response));
						check_value("vertex_data", wide_t'(e.vertex_data), wide_t'(vertex_data));
						check_value("graph_data", wide_t'(e.graph_data), wide_t'(graph_data));
					end
				end
			join
			step();
			if (route_queue.size() != 0) begin
				errors++;
				test_errors++;
				$display("router never delivered %0d items in %s", route_queue.size(), test_name);
				route_queue.delete();
			end
			end_test();
		end

		begin_test("arbitration");
		graph_first    = 1'b0;
		vertex_command = random_command();
		graph_command  = random_command();
		for (int i = 0; i < ARB_ROUNDS + SINGLE_ROUNDS; i++) begin
			// the graph client requests alone for the last rounds
			if (i == ARB_ROUNDS)
				vertex_command = '0;
			@(negedge clock);
			grants = grant_reference(graph_first, vertex_command.valid, graph_command.valid);
			check_value("vertex_grant", wide_t'(grants[1]), wide_t'(vertex_grant));
			check_value("graph_grant", wide_t'(grants[0]), wide_t'(graph_grant));
			granted = '0;
			if (grants[1])
				granted = vertex_command;
			else if (grants[0])
				granted = graph_command;
			step();
			check_value("read_command_out", wide_t'(granted), wide_t'(read_command_out));
			// the granted client moves on to its next command
			if (grants[1]) begin
				vertex_command = random_command();
				graph_first    = 1'b1;
			end else if (grants[0]) begin
				graph_command = random_command();
				graph_first   = 1'b0;
			end
		end
		vertex_command = '0;
		graph_command  = '0;
		repeat (2) step();
		check_value("read_command_out idle", wide_t'(0), wide_t'(read_command_out));
		end_test();

		begin_test("completion");
		done_part             = $urandom_range(wed_request_in.num_vertices);
		vertex_done_count     = done_part;
		vertex_filtered_count = wed_request_in.num_vertices - done_part;
		edge_done_count       = wed_request_in.num_edges;
		expected_done = done_reference(wed_request_in, vertex_done_count,
			vertex_filtered_count, edge_done_count);
		expected_return.var1 = vertex_done_count + vertex_filtered_count;
		expected_return.var2 = edge_done_count;
		repeat (3) step();
		check_value("cu_done before latency", wide_t'(1'b0), wide_t'(cu_done));
		step();
		check_value("cu_done", wide_t'(expected_done), wide_t'(cu_done));
		check_value("cu_return", wide_t'(expected_return), wide_t'(cu_return));
		end_test();

		begin_test("mismatch");
		for (int k = 0; k < 2; k++) begin
			// first the vertex total is off by one, then the edge total
			if (k == 0) begin
				vertex_filtered_count = vertex_filtered_count + 1;
			end else begin
				vertex_filtered_count = wed_request_in.num_vertices - done_part;
				edge_done_count       = edge_done_count + 1;
			end
			expected_done = done_reference(wed_request_in, vertex_done_count,
				vertex_filtered_count, edge_done_count);
			repeat (4) step();
			repeat (4) begin
				check_value("cu_done", wide_t'(expected_done), wide_t'(cu_done));
				step();
			end
		end
		end_test();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* filelist.f */
verilog/cu_bus_pkg.sv
verilog/cu_job_pkg.sv
verilog/cu_config_latch.sv
verilog/cu_response_router.sv
verilog/cu_read_arbiter.sv
verilog/cu_done_tracker.sv
verilog/cu_control.sv
bench/cu_clock_gen.sv
bench/cu_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the cu_control testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module cu_control_tb -f filelist.f -o cu_control_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cu_control_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
exit 0
